// ==== logic/sched_config.svh ====
// Sizing constants for the issue stage.
// Include this header wherever the window depth, index width or MUL
// latency is needed. The package builds its index and mask types from it.

`ifndef SCHED_CONFIG_SVH
`define SCHED_CONFIG_SVH

// Number of entries in the reorder window
// The scheduler searches all of them, so the search window equals this depth
`define ROB_ENTRIES 8

// Bits needed to index one window entry
`define ROB_NDX_W 3

// Occupancy of ALU0 while it runs a MUL
`define MUL_CYCLES 4

`endif

// ==== logic/sched_pkg.sv ====
// Shared types for the issue stage: opcodes, execution slots, window
// indices and the packed records that pass between the blocks.
// Import with a wildcard in the module header of any block that uses them.

`include "sched_config.svh"

package sched_pkg;

	// Instruction opcodes as they arrive from the front end
	typedef enum logic [1:0] {
		OP_ADD,
		OP_MUL,
		OP_BRA,
		OP_SYNC
	} op_e;

	// Execution slots, also used to index the per-slot timers
	typedef enum logic [1:0] {
		UNIT_ALU0,
		UNIT_ALU1,
		UNIT_FCU
	} unit_e;

	typedef logic [`ROB_NDX_W-1:0] rob_ndx_t;
	typedef logic [`ROB_ENTRIES-1:0] rob_bitmask_t;

	// Incoming instruction word, the tag is carried through untouched
	typedef struct packed {
		op_e op;
		logic [5:0] tag;
	} instr_t;

	// One window entry
	// The alu, alu0, fc and sync flags are the decoded unit classes
	typedef struct packed {
		logic v;
		op_e op;
		logic [5:0] tag;
		logic alu;
		logic alu0;
		logic fc;
		logic sync;
		logic issued;
		logic done;
	} rob_entry_t;

	// What a scheduler slot hands to its execution unit
	typedef struct packed {
		logic v;
		rob_ndx_t ndx;
		op_e op;
		logic [5:0] tag;
	} issue_t;

	// Retired instruction and the slot that ran it
	typedef struct packed {
		logic [5:0] tag;
		op_e op;
		unit_e unit;
	} retire_t;

endpackage

// ==== logic/dispatch_decode.sv ====
// Dispatch stage: takes instruction words on a valid/ready level pair,
// decodes the opcode into unit-class flags and registers one entry per
// cycle toward the reorder window, which writes it on the following edge.

`include "sched_config.svh"

module dispatch_decode import sched_pkg::*; (
	input logic clk,
	input logic rst,
	input logic instr_v,
	input instr_t instr,
	input logic [`ROB_NDX_W:0] free_cnt,
	output logic dispatch_ready,
	output rob_entry_t dec_entry
);

	logic accept;
	logic [`ROB_NDX_W:0] in_flight;
	rob_entry_t decoded;

	// A registered entry not yet written still needs a free slot
	// The window's free count only drops after that write, so count it here
	assign in_flight = {{`ROB_NDX_W{1'b0}}, dec_entry.v};
	assign dispatch_ready = free_cnt > in_flight;
	assign accept = instr_v && dispatch_ready;

	// ==========================================================
	// Opcode decode
	// ==========================================================
	always_comb begin
		decoded = '0;
		decoded.op = instr.op;
		decoded.tag = instr.tag;
		case (instr.op)
			OP_ADD: decoded.alu = 1'b1;
			OP_MUL: begin
				// MUL only exists on ALU0
				decoded.alu = 1'b1;
				decoded.alu0 = 1'b1;
			end
			OP_BRA: decoded.fc = 1'b1;
			OP_SYNC: begin
				// SYNC runs on the FCU and fences younger entries
				decoded.fc = 1'b1;
				decoded.sync = 1'b1;
			end
			default: decoded.alu = 1'b0;
		endcase
	end

	// The valid bit lasts one cycle per accepted word
	always_ff @(posedge clk) begin
		if (rst) begin
			dec_entry.v <= 1'b0;
		end else begin
			dec_entry.v <= accept;
		end
		if (accept) begin
			dec_entry.op <= decoded.op;
			dec_entry.tag <= decoded.tag;
			dec_entry.alu <= decoded.alu;
			dec_entry.alu0 <= decoded.alu0;
			dec_entry.fc <= decoded.fc;
			dec_entry.sync <= decoded.sync;
			dec_entry.issued <= decoded.issued;
			dec_entry.done <= decoded.done;
		end
	end

endmodule

// ==== logic/rob_window.sv ====
// Circular reorder window. New entries go in at the tail, the scheduler
// marks entries issued, the execution units mark them done, and the head
// retires in program order, at most one entry per cycle.
// Retire is combinational from the head entry and has no back-pressure.

`include "sched_config.svh"

module rob_window import sched_pkg::*; (
	input logic clk,
	input logic rst,
	input rob_entry_t dec_entry,
	input rob_bitmask_t issue_mask,
	input issue_t issue_alu0,
	input issue_t issue_alu1,
	input issue_t issue_fcu,
	input logic done_alu0,
	input logic done_alu1,
	input logic done_fcu,
	input rob_ndx_t done_alu0_ndx,
	input rob_ndx_t done_alu1_ndx,
	input rob_ndx_t done_fcu_ndx,
	output rob_entry_t [`ROB_ENTRIES-1:0] rob,
	output rob_ndx_t head,
	output logic [`ROB_NDX_W:0] free_cnt,
	output logic retire_v,
	output retire_t retire
);

	localparam logic [`ROB_NDX_W:0] DEPTH = `ROB_ENTRIES;

	rob_ndx_t tail;
	logic [`ROB_NDX_W:0] count;
	logic do_write;
	// Slot that ran each entry, recorded when it issues
	unit_e slot_q [`ROB_ENTRIES];

	assign do_write = dec_entry.v;
	assign free_cnt = DEPTH - count;

	// The head leaves as soon as it is done
	assign retire_v = rob[head].v && rob[head].done;
	assign retire = '{tag: rob[head].tag, op: rob[head].op, unit: slot_q[head]};

	// ==========================================================
	// Pointers and occupancy
	// ==========================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (do_write) begin
				tail <= tail + 1'b1;
			end
			if (retire_v) begin
				head <= head + 1'b1;
			end
			case ({do_write, retire_v})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// ==========================================================
	// Entry state
	// ==========================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `ROB_ENTRIES; i++) begin
				rob[i].v <= 1'b0;
			end
		end else begin
			for (int i = 0; i < `ROB_ENTRIES; i++) begin
				if (issue_mask[i]) begin
					rob[i].issued <= 1'b1;
				end
			end
			// Completion strobes can land on three different entries at once
			if (done_alu0) begin
				rob[done_alu0_ndx].done <= 1'b1;
			end
			if (done_alu1) begin
				rob[done_alu1_ndx].done <= 1'b1;
			end
			if (done_fcu) begin
				rob[done_fcu_ndx].done <= 1'b1;
			end
			if (retire_v) begin
				rob[head].v <= 1'b0;
			end
			// The tail never points at a live entry while ready allowed a write
			if (do_write) begin
				rob[tail] <= dec_entry;
			end
		end
	end

	// Slot record, kept only for the retire report
	always_ff @(posedge clk) begin
		if (issue_alu0.v) begin
			slot_q[issue_alu0.ndx] <= UNIT_ALU0;
		end
		if (issue_alu1.v) begin
			slot_q[issue_alu1.ndx] <= UNIT_ALU1;
		end
		if (issue_fcu.v) begin
			slot_q[issue_fcu.ndx] <= UNIT_FCU;
		end
	end

endmodule

// ==== logic/issue_sched.sv ====
// Oldest-first issue selector. Walks the window from the head and grants
// each idle slot the oldest entry it can run, under the ALU0-only rule
// for MUL and the SYNC fence. Purely combinational, one pass per cycle,
// and the grants take effect on the next edge.

`include "sched_config.svh"

module issue_sched import sched_pkg::*; (
	input rob_entry_t [`ROB_ENTRIES-1:0] rob,
	input rob_ndx_t head,
	input logic alu0_idle,
	input logic alu1_idle,
	input logic fcu_idle,
	output issue_t issue_alu0,
	output issue_t issue_alu1,
	output issue_t issue_fcu,
	output rob_bitmask_t issue_mask
);

	// Window indices in age order, heads[0] is the oldest entry
	rob_ndx_t heads [`ROB_ENTRIES];

	always_comb begin
		for (int m = 0; m < `ROB_ENTRIES; m++) begin
			heads[m] = head + rob_ndx_t'(m);
		end
	end

	// Builds the slot record for one granted entry
	function automatic issue_t to_issue(rob_ndx_t ndx, rob_entry_t e);
		issue_t r;
		r.v = 1'b1;
		r.ndx = ndx;
		r.op = e.op;
		r.tag = e.tag;
		return r;
	endfunction

	// ==========================================================
	// Slot selection
	// ==========================================================
	// The taken flags carry state from older to younger entries in a
	// single sweep, so there is no combinational loop between slots
	always_comb begin
		rob_entry_t e;
		rob_ndx_t ndx;
		logic blocked;
		logic took_alu0;
		logic took_alu1;
		logic took_fcu;

		issue_alu0 = '0;
		issue_alu1 = '0;
		issue_fcu = '0;
		issue_mask = '0;
		blocked = 1'b0;
		took_alu0 = 1'b0;
		took_alu1 = 1'b0;
		took_fcu = 1'b0;

		for (int hd = 0; hd < `ROB_ENTRIES; hd++) begin
			ndx = heads[hd];
			e = rob[ndx];
			// Any valid entry not yet issued is a candidate unless fenced
			if (e.v && !e.issued && !blocked) begin
				// The else chain keeps one entry from taking two slots
				if (!took_alu0 && alu0_idle && e.alu) begin
					issue_alu0 = to_issue(ndx, e);
					issue_mask[ndx] = 1'b1;
					took_alu0 = 1'b1;
				end else if (!took_alu1 && alu1_idle && e.alu && !e.alu0) begin
					issue_alu1 = to_issue(ndx, e);
					issue_mask[ndx] = 1'b1;
					took_alu1 = 1'b1;
				end else if (!took_fcu && fcu_idle && e.fc) begin
					issue_fcu = to_issue(ndx, e);
					issue_mask[ndx] = 1'b1;
					took_fcu = 1'b1;
				end
			end
			// A SYNC still in flight fences everything younger than itself
			// It may issue on this pass, but nothing behind it may
			if (e.v && e.sync && !e.done) begin
				blocked = 1'b1;
			end
		end
	end

endmodule

// ==== logic/exec_units.sv ====
// Execution slot timers for ALU0, ALU1 and the FCU. Each slot loads a
// countdown with the opcode latency when it is issued to, reports idle
// while the count is zero and strobes done in its last busy cycle,
// together with the window index of the entry it ran.

`include "sched_config.svh"

module exec_units import sched_pkg::*; (
	input logic clk,
	input logic rst,
	input issue_t issue_alu0,
	input issue_t issue_alu1,
	input issue_t issue_fcu,
	output logic alu0_idle,
	output logic alu1_idle,
	output logic fcu_idle,
	output logic done_alu0,
	output logic done_alu1,
	output logic done_fcu,
	output rob_ndx_t done_alu0_ndx,
	output rob_ndx_t done_alu1_ndx,
	output rob_ndx_t done_fcu_ndx
);

	localparam int CNT_W = $clog2(`MUL_CYCLES + 1);
	localparam int NSLOT = 3;

	// Slot arrays are indexed by unit_e
	issue_t slot_in [NSLOT];
	logic [CNT_W-1:0] cnt [NSLOT];
	rob_ndx_t run_ndx [NSLOT];

	// Busy cycles for each opcode
	function automatic logic [CNT_W-1:0] op_latency(op_e op);
		case (op)
			OP_MUL: return CNT_W'(`MUL_CYCLES);
			default: return CNT_W'(1);
		endcase
	endfunction

	assign slot_in[UNIT_ALU0] = issue_alu0;
	assign slot_in[UNIT_ALU1] = issue_alu1;
	assign slot_in[UNIT_FCU] = issue_fcu;

	// ==========================================================
	// Occupancy countdowns
	// ==========================================================
	// The scheduler only issues to an idle slot, so a load never
	// overlaps a running count
	always_ff @(posedge clk) begin
		for (int i = 0; i < NSLOT; i++) begin
			if (rst) begin
				cnt[i] <= '0;
			end else if (slot_in[i].v) begin
				cnt[i] <= op_latency(slot_in[i].op);
			end else if (cnt[i] != '0) begin
				cnt[i] <= cnt[i] - 1'b1;
			end
			if (slot_in[i].v) begin
				run_ndx[i] <= slot_in[i].ndx;
			end
		end
	end

	assign alu0_idle = (cnt[UNIT_ALU0] == '0);
	assign alu1_idle = (cnt[UNIT_ALU1] == '0);
	assign fcu_idle = (cnt[UNIT_FCU] == '0);

	// A count of one is the final busy cycle
	assign done_alu0 = (cnt[UNIT_ALU0] == CNT_W'(1));
	assign done_alu1 = (cnt[UNIT_ALU1] == CNT_W'(1));
	assign done_fcu = (cnt[UNIT_FCU] == CNT_W'(1));

	assign done_alu0_ndx = run_ndx[UNIT_ALU0];
	assign done_alu1_ndx = run_ndx[UNIT_ALU1];
	assign done_fcu_ndx = run_ndx[UNIT_FCU];

endmodule

// ==== logic/issue_core.sv ====
// Top of the issue stage. Instructions enter on instr_v/dispatch_ready,
// the three slot records show what issues each cycle, and retire_v
// marks each in-order completion.

`include "sched_config.svh"

module issue_core import sched_pkg::*; (
	input logic clk,
	input logic rst,
	input logic instr_v,
	input instr_t instr,
	output logic dispatch_ready,
	output issue_t issue_alu0,
	output issue_t issue_alu1,
	output issue_t issue_fcu,
	output logic retire_v,
	output retire_t retire
);

	rob_entry_t dec_entry;
	logic [`ROB_NDX_W:0] free_cnt;
	rob_entry_t [`ROB_ENTRIES-1:0] rob;
	rob_ndx_t head;
	rob_bitmask_t issue_mask;
	logic alu0_idle;
	logic alu1_idle;
	logic fcu_idle;
	logic done_alu0;
	logic done_alu1;
	logic done_fcu;
	rob_ndx_t done_alu0_ndx;
	rob_ndx_t done_alu1_ndx;
	rob_ndx_t done_fcu_ndx;

	// Decoded entries are written into the window one edge after acceptance
	dispatch_decode dispatch_decode_i (
		.clk(clk),
		.rst(rst),
		.instr_v(instr_v),
		.instr(instr),
		.free_cnt(free_cnt),
		.dispatch_ready(dispatch_ready),
		.dec_entry(dec_entry)
	);

	rob_window rob_window_i (
		.clk(clk),
		.rst(rst),
		.dec_entry(dec_entry),
		.issue_mask(issue_mask),
		.issue_alu0(issue_alu0),
		.issue_alu1(issue_alu1),
		.issue_fcu(issue_fcu),
		.done_alu0(done_alu0),
		.done_alu1(done_alu1),
		.done_fcu(done_fcu),
		.done_alu0_ndx(done_alu0_ndx),
		.done_alu1_ndx(done_alu1_ndx),
		.done_fcu_ndx(done_fcu_ndx),
		.rob(rob),
		.head(head),
		.free_cnt(free_cnt),
		.retire_v(retire_v),
		.retire(retire)
	);

	issue_sched issue_sched_i (
		.rob(rob),
		.head(head),
		.alu0_idle(alu0_idle),
		.alu1_idle(alu1_idle),
		.fcu_idle(fcu_idle),
		.issue_alu0(issue_alu0),
		.issue_alu1(issue_alu1),
		.issue_fcu(issue_fcu),
		.issue_mask(issue_mask)
	);

	exec_units exec_units_i (
		.clk(clk),
		.rst(rst),
		.issue_alu0(issue_alu0),
		.issue_alu1(issue_alu1),
		.issue_fcu(issue_fcu),
		.alu0_idle(alu0_idle),
		.alu1_idle(alu1_idle),
		.fcu_idle(fcu_idle),
		.done_alu0(done_alu0),
		.done_alu1(done_alu1),
		.done_fcu(done_fcu),
		.done_alu0_ndx(done_alu0_ndx),
		.done_alu1_ndx(done_alu1_ndx),
		.done_fcu_ndx(done_fcu_ndx)
	);

endmodule

// ==== tb/issue_core_checker.sv ====
// Concurrent checks on the three issue slots of the issue stage.
// Bound into the top level, where the idle levels and done strobes
// between the scheduler and the execution units are visible.

module issue_core_checker import sched_pkg::*; (
	input logic clk,
	input logic rst,
	input issue_t issue_alu0,
	input issue_t issue_alu1,
	input issue_t issue_fcu,
	input logic alu0_idle,
	input logic alu1_idle,
	input logic fcu_idle,
	input logic done_alu0,
	input logic done_alu1,
	input logic done_fcu
);

	// Each window entry takes at most one slot per cycle
	distinct_ndx: assert property (@(posedge clk) disable iff (rst)
		!((issue_alu0.v && issue_alu1.v && issue_alu0.ndx == issue_alu1.ndx)
		|| (issue_alu0.v && issue_fcu.v && issue_alu0.ndx == issue_fcu.ndx)
		|| (issue_alu1.v && issue_fcu.v && issue_alu1.ndx == issue_fcu.ndx)))
		else $error("Two issue slots carry the same window index");

	// MUL exists on ALU0 only
	no_mul_alu1: assert property (@(posedge clk) disable iff (rst)
		issue_alu1.v |-> issue_alu1.op != OP_MUL)
		else $error("MUL issued on ALU1");

	// A slot only takes new work while its timer has run down to zero
	idle_issue: assert property (@(posedge clk) disable iff (rst)
		(!issue_alu0.v || alu0_idle) && (!issue_alu1.v || alu1_idle)
		&& (!issue_fcu.v || fcu_idle))
		else $error("Issue to a busy slot");

	// Counters are cleared after the first reset edge
	reset_done: assert property (@(posedge clk)
		rst && $past(rst) |-> !(done_alu0 || done_alu1 || done_fcu))
		else $error("Done strobe high during reset");

endmodule

bind issue_core issue_core_checker checker_i (
	.clk(clk),
	.rst(rst),
	.issue_alu0(issue_alu0),
	.issue_alu1(issue_alu1),
	.issue_fcu(issue_fcu),
	.alu0_idle(alu0_idle),
	.alu1_idle(alu1_idle),
	.fcu_idle(fcu_idle),
	.done_alu0(done_alu0),
	.done_alu1(done_alu1),
	.done_fcu(done_fcu)
);

// ==== tb/issue_core_tb.sv ====
// Directed testbench for the issue stage top level.
// Drives instruction words through the dispatch handshake, watches every
// issue and retire at the rising edge and checks them against the slot,
// ordering and SYNC rules. Tests run back to back from one reset.

`include "sched_config.svh"

module issue_core_tb import sched_pkg::*; ();

	localparam int TIMEOUT = 200;

	logic clk = 1'b0;
	logic rst;
	logic instr_v;
	instr_t instr;
	logic dispatch_ready;
	issue_t issue_alu0;
	issue_t issue_alu1;
	issue_t issue_fcu;
	logic retire_v;
	retire_t retire;

	int checks = 0;
	int errors = 0;
	int seq = 0;
	int cycle = 0;
	int sync_seq = -1;
	int sync_cyc = 0;
	int seed = 6619;
	bit saw_stall = 1'b0;

	// Program order of everything dispatched and not yet retired
	instr_t exp_q [$];
	issue_t issue_log [$];
	retire_t retire_log [$];

	// Per-tag records, tags stay unique while in flight
	op_e op_of [64];
	unit_e issued_unit [64];
	int seq_of [64];
	int issue_cyc [64];
	bit outstanding [64];
	bit was_issued [64];

	always #4 clk = ~clk;

	issue_core dut_i (
		.clk(clk),
		.rst(rst),
		.instr_v(instr_v),
		.instr(instr),
		.dispatch_ready(dispatch_ready),
		.issue_alu0(issue_alu0),
		.issue_alu1(issue_alu1),
		.issue_fcu(issue_fcu),
		.retire_v(retire_v),
		.retire(retire)
	);

	// ============================================================
	// Compare tasks
	// ============================================================
	task automatic check_retire(input string name, input retire_t got, input retire_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_unit(input string name, input unit_e got, input unit_e exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_tag(input string name, input logic [5:0] got, input logic [5:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_op(input string name, input op_e got, input op_e exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	// MUL is ALU0 only, BRA and SYNC are FCU only, ADD may take either ALU
	function automatic unit_e rule_unit(input op_e op, input unit_e slot);
		case (op)
			OP_MUL: return UNIT_ALU0;
			OP_ADD: return (slot == UNIT_FCU) ? UNIT_ALU0 : slot;
			default: return UNIT_FCU;
		endcase
	endfunction

	// ============================================================
	// Issue and retire monitor
	// ============================================================
	task automatic note_issue(input issue_t iss, input unit_e slot);
		int s;
		if (!outstanding[iss.tag] || was_issued[iss.tag]) begin
			errors++;
			$display("Tag 0x%h issued on %s while not waiting to issue", iss.tag, slot.name());
		end
		s = seq_of[iss.tag];
		check_op("issue op", iss.op, op_of[iss.tag]);
		check_unit("issue slot", slot, rule_unit(op_of[iss.tag], slot));
		// The SYNC done strobe comes one cycle after its issue at the earliest
		if (sync_seq >= 0 && s > sync_seq && cycle <= sync_cyc + 1) begin
			errors++;
			$display("Tag 0x%h issued before the older SYNC completed", iss.tag);
		end
		if (op_of[iss.tag] == OP_SYNC) begin
			sync_seq = s;
			sync_cyc = cycle;
		end
		issued_unit[iss.tag] = slot;
		issue_cyc[iss.tag] = cycle;
		was_issued[iss.tag] = 1'b1;
		issue_log.push_back(iss);
	endtask

	task automatic note_retire(input retire_t r);
		instr_t front;
		retire_t exp;
		retire_log.push_back(r);
		if (exp_q.size() == 0) begin
			errors++;
			$display("Tag 0x%h retired with nothing outstanding", r.tag);
		end else begin
			front = exp_q.pop_front();
			exp = '{tag: front.tag, op: front.op, unit: issued_unit[front.tag]};
			check_tag("retire.tag", r.tag, front.tag);
			check_retire("retire", r, exp);
			if (!was_issued[front.tag]) begin
				errors++;
				$display("Tag 0x%h retired without being issued", front.tag);
			end
			outstanding[front.tag] = 1'b0;
			was_issued[front.tag] = 1'b0;
		end
	endtask

	// The FCU goes first so a SYNC is seen before younger grants in its cycle
	always @(posedge clk) begin
		if (!rst) begin
			cycle++;
			if (issue_fcu.v) begin
				note_issue(issue_fcu, UNIT_FCU);
			end
			if (issue_alu0.v) begin
				note_issue(issue_alu0, UNIT_ALU0);
			end
			if (issue_alu1.v) begin
				note_issue(issue_alu1, UNIT_ALU1);
			end
			if (retire_v) begin
				note_retire(retire);
			end
		end
	end

	// ============================================================
	// Stimulus
	// ============================================================
	// Called at a falling edge and returns at a falling edge
	task automatic dispatch(input op_e op);
		instr_t w;
		int waited;
		w.op = op;
		w.tag = seq[5:0];
		instr_v = 1'b1;
		instr = w;
		waited = 0;
		while (!dispatch_ready && waited < TIMEOUT) begin
			saw_stall = 1'b1;
			@(negedge clk);
			waited++;
		end
		if (dispatch_ready) begin
			op_of[w.tag] = op;
			seq_of[w.tag] = seq;
			outstanding[w.tag] = 1'b1;
			exp_q.push_back(w);
			seq++;
			@(posedge clk);
		end else begin
			errors++;
			$display("dispatch_ready stayed low for %0d cycles", TIMEOUT);
		end
		@(negedge clk);
		instr_v = 1'b0;
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d instructions did not retire in time", exp_q.size());
		end
	endtask

	task automatic in_order_stream();
		dispatch(OP_ADD);
		dispatch(OP_BRA);
		dispatch(OP_MUL);
		dispatch(OP_ADD);
		dispatch(OP_SYNC);
		dispatch(OP_ADD);
		dispatch(OP_BRA);
		dispatch(OP_ADD);
		drain();
	endtask

	// Younger ADDs and a BRA wait behind a SYNC that waits behind a MUL
	task automatic sync_fence();
		dispatch(OP_MUL);
		dispatch(OP_SYNC);
		dispatch(OP_ADD);
		dispatch(OP_ADD);
		dispatch(OP_BRA);
		dispatch(OP_SYNC);
		dispatch(OP_MUL);
		drain();
	endtask

	task automatic parallel_alu();
		logic [5:0] t_mul;
		logic [5:0] t_add;
		t_mul = seq[5:0];
		t_add = t_mul + 6'd1;
		dispatch(OP_MUL);
		dispatch(OP_ADD);
		dispatch(OP_ADD);
		drain();
		// With ALU0 held by the MUL the first ADD has to take ALU1
		check_unit("first ADD slot", issued_unit[t_add], UNIT_ALU1);
		if (issue_cyc[t_add] >= issue_cyc[t_mul] + `MUL_CYCLES) begin
			errors++;
			$display("ADD did not issue while the MUL was running");
		end
	endtask

	task automatic window_full();
		saw_stall = 1'b0;
		for (int i = 0; i < `ROB_ENTRIES + 4; i++) begin
			dispatch(OP_MUL);
		end
		drain();
		if (!saw_stall) begin
			errors++;
			$display("dispatch_ready never dropped with the window full");
		end
	endtask

	task automatic random_mix();
		int r;
		for (int i = 0; i < 200; i++) begin
			r = $random(seed);
			dispatch(op_e'(r[1:0]));
		end
		drain();
	endtask

	initial begin
		rst = 1'b1;
		instr_v = 1'b0;
		instr = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		in_order_stream();
		sync_fence();
		parallel_alu();
		window_full();
		random_mix();
		if (issue_log.size() != seq || retire_log.size() != seq) begin
			errors++;
			$display("Dispatched %0d, issued %0d, retired %0d", seq, issue_log.size(),
				retire_log.size());
		end
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+logic
logic/sched_pkg.sv
logic/dispatch_decode.sv
logic/rob_window.sv
logic/issue_sched.sv
logic/exec_units.sv
logic/issue_core.sv
tb/issue_core_checker.sv
tb/issue_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the issue stage testbench with Verilator, run it and scan the log

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f verilog.f --top-module issue_core_tb -o issue_core_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/issue_core_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
	echo "Simulation reported failure"
	exit 1
fi

echo "Simulation passed"
exit 0
